// ==== tb_clk_gen.sv ====
module tb_clk_gen (
   output logic o_clk,
   output logic o_rst_n
);
   timeunit 1ns;
   timeprecision 1ps;

   // 20 ns period
   initial begin
      o_clk = 1'b0;
      forever #10 o_clk = ~o_clk;
   end

   // Four rising edges in reset, released on a falling edge
   initial begin
      o_rst_n = 1'b0;
      repeat (4) @(posedge o_clk);
      @(negedge o_clk);
      o_rst_n = 1'b1;
   end

endmodule

// ==== tb_tiny_serv.sv ====
`include "tiny_serv_config.svh"

module tb_tiny_serv;
   timeunit 1ns;
   timeprecision 1ps;

   logic        clk;
   logic        rst_n;
   logic [31:0] ibus_adr;
   logic        ibus_cyc;
   logic [31:0] ibus_rdt;
   logic        ibus_ack;
   logic [31:0] dbus_adr;
   logic [31:0] dbus_dat;
   logic        dbus_cyc;
   logic        dbus_ack;

   logic [31:0] imem [0:255];
   logic [31:0] xreg [0:31];
   logic [31:0] ref_pc;
   logic [31:0] exp_adr;
   logic [31:0] exp_dat;
   logic        store_due;
   string       store_name [$];
   int          seed;
   int          n_stores;
   int          n_checked;
   int          prog_idx;

   tb_clk_gen u_clk_gen (
      .o_clk   (clk),
      .o_rst_n (rst_n)
   );

   tiny_serv_top u_dut (
      .clk        (clk),
      .i_rst_n    (rst_n),
      .o_ibus_adr (ibus_adr),
      .o_ibus_cyc (ibus_cyc),
      .i_ibus_rdt (ibus_rdt),
      .i_ibus_ack (ibus_ack),
      .o_dbus_adr (dbus_adr),
      .o_dbus_dat (dbus_dat),
      .o_dbus_cyc (dbus_cyc),
      .i_dbus_ack (dbus_ack)
   );

   function automatic logic [31:0] op_imm(input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [4:0] rs1, input logic [11:0] imm);
      return {imm, rs1, f3, rd, 7'b0010011};
   endfunction

   function automatic logic [31:0] op_reg(input logic [6:0] f7, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [4:0] rs2);
      return {f7, rs2, rs1, f3, rd, 7'b0110011};
   endfunction

   function automatic logic [31:0] sw_instr(input logic [4:0] rs2, input logic [4:0] rs1,
                                            input logic [11:0] imm);
      return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
   endfunction

   function automatic logic [31:0] lui_instr(input logic [4:0] rd, input logic [19:0] imm);
      return {imm, rd, 7'b0110111};
   endfunction

   function automatic logic [31:0] jal_instr(input logic [4:0] rd, input logic [20:0] imm);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
   endfunction

   task automatic stop_run(input string why);
      $display("%s", why);
      $display(">>> FAIL");
      $fatal(1);
   endtask

   task automatic check_word(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
      assert (act === exp)
         else stop_run($sformatf("[FAIL] %s expected %08h actual %08h", name, exp, act));
   endtask

   task automatic emit(input logic [31:0] ins);
      imem[prog_idx] = ins;
      if (ins[6:0] == 7'b0100011) begin
         n_stores++;
      end
      prog_idx++;
   endtask

   task automatic emit_sw(input logic [4:0] rs2, input logic [4:0] rs1,
                          input logic [11:0] imm, input string name);
      store_name.push_back(name);
      emit(sw_instr(rs2, rs1, imm));
   endtask

   task automatic load_program();
      emit(lui_instr(5'd1, 20'h12345));
      emit(op_imm(3'b000, 5'd1, 5'd1, 12'h678));
      emit(op_imm(3'b000, 5'd2, 5'd0, 12'hFFF));
      emit(op_reg(7'h00, 3'b000, 5'd3, 5'd1, 5'd2));
      emit_sw(5'd3, 5'd0, 12'h100, "ADD carry chain");
      emit(op_reg(7'h20, 3'b000, 5'd4, 5'd1, 5'd2));
      emit_sw(5'd4, 5'd0, 12'h104, "SUB");
      emit(op_imm(3'b100, 5'd5, 5'd1, 12'hF00));
      emit(op_imm(3'b110, 5'd6, 5'd1, 12'h0F0));
      emit(op_imm(3'b111, 5'd7, 5'd1, 12'h7FF));
      emit(op_reg(7'h00, 3'b100, 5'd8, 5'd5, 5'd6));
      emit(op_reg(7'h00, 3'b110, 5'd9, 5'd8, 5'd7));
      emit(op_reg(7'h00, 3'b111, 5'd10, 5'd5, 5'd6));
      emit_sw(5'd8, 5'd0, 12'h108, "XORI ORI XOR");
      emit_sw(5'd9, 5'd0, 12'h10C, "ANDI OR");
      emit_sw(5'd10, 5'd0, 12'h110, "AND");
      emit(op_imm(3'b000, 5'd0, 5'd1, 12'h005));
      emit_sw(5'd0, 5'd0, 12'h114, "x0 write ignored");
      emit(op_imm(3'b000, 5'd13, 5'd0, 12'h200));
      emit(jal_instr(5'd11, 21'd12));
      // Two filler words jumped over
      prog_idx += 2;
      emit_sw(5'd11, 5'd13, 12'hFFC, "JAL link");
      emit(op_reg(7'h20, 3'b000, 5'd14, 5'd0, 5'd1));
      emit_sw(5'd14, 5'd0, 12'h118, "SUB negate");
   endtask

   // ISA reference for the fetched word
   task automatic exec_ref(input logic [31:0] ins);
      logic [4:0]  rd;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] imm_i;
      logic [31:0] imm_s;
      logic [31:0] imm_j;
      logic [31:0] res;
      logic [31:0] next_pc;
      logic        wr;
      rd        = ins[11:7];
      a         = xreg[ins[19:15]];
      b         = xreg[ins[24:20]];
      imm_i     = {{20{ins[31]}}, ins[31:20]};
      imm_s     = {{20{ins[31]}}, ins[31:25], ins[11:7]};
      imm_j     = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
      res       = '0;
      wr        = 1'b0;
      store_due = 1'b0;
      next_pc   = ref_pc + 32'd4;
      case (ins[6:0])
         7'b0010011: begin
            wr = 1'b1;
            case (ins[14:12])
               3'b000:  res = a + imm_i;
               3'b100:  res = a ^ imm_i;
               3'b110:  res = a | imm_i;
               3'b111:  res = a & imm_i;
               default: wr = 1'b0;
            endcase
         end
         7'b0110011: begin
            wr = 1'b1;
            case (ins[14:12])
               3'b000:  res = ins[30] ? a - b : a + b;
               3'b100:  res = a ^ b;
               3'b110:  res = a | b;
               3'b111:  res = a & b;
               default: wr = 1'b0;
            endcase
         end
         7'b0110111: begin
            wr  = 1'b1;
            res = {ins[31:12], 12'h000};
         end
         7'b1101111: begin
            wr      = 1'b1;
            res     = ref_pc + 32'd4;
            next_pc = ref_pc + imm_j;
         end
         7'b0100011: begin
            if (ins[14:12] == 3'b010) begin
               store_due = 1'b1;
               exp_adr   = a + imm_s;
               exp_dat   = b;
            end
         end
         default: begin
         end
      endcase
      if (wr && rd != 5'd0) begin
         xreg[rd] = res;
      end
      ref_pc = next_pc;
   endtask

   task automatic wait_cyc(input bit data_side);
      int n;
      n = 0;
      while (!(data_side ? dbus_cyc : ibus_cyc) && n < 200) begin
         @(negedge clk);
         n++;
      end
      if (!(data_side ? dbus_cyc : ibus_cyc)) begin
         stop_run(data_side ? "store bus cycle never started within 200 cycles"
                            : "fetch bus cycle never started within 200 cycles");
      end
   endtask

   task automatic random_wait();
      int d;
      d = $unsigned($random(seed)) % 4;
      repeat (d) @(negedge clk);
   endtask

   always @(negedge clk) begin
      if (u_dut.u_chk.fail_cnt != 0) begin
         stop_run("a bus protocol assertion failed");
      end
   end

   initial begin
      int k;
      ibus_rdt  = '0;
      ibus_ack  = 1'b0;
      dbus_ack  = 1'b0;
      seed      = 32;
      n_stores  = 0;
      n_checked = 0;
      prog_idx  = 0;
      store_due = 1'b0;
      ref_pc    = `TS_RESET_PC;
      // Filler is ADDI x0 with the word index as immediate
      for (k = 0; k < 256; k++) begin
         imem[k] = op_imm(3'b000, 5'd0, 5'd0, 12'(k));
      end
      for (k = 0; k < 32; k++) begin
         xreg[k] = '0;
      end
      load_program();

      k = 0;
      while (rst_n !== 1'b1 && k < 200) begin
         @(negedge clk);
         k++;
      end
      if (rst_n !== 1'b1) begin
         stop_run("reset was never released");
      end

      for (k = 0; k < 64 && n_checked < n_stores; k++) begin
         wait_cyc(1'b0);
         check_word("fetch address", ref_pc, ibus_adr);
         random_wait();
         ibus_rdt = imem[ibus_adr[9:2]];
         ibus_ack = 1'b1;
         @(negedge clk);
         ibus_ack = 1'b0;
         exec_ref(ibus_rdt);
         if (store_due) begin
            wait_cyc(1'b1);
            check_word({store_name[n_checked], " address"}, exp_adr, dbus_adr);
            check_word({store_name[n_checked], " data"}, exp_dat, dbus_dat);
            random_wait();
            dbus_ack = 1'b1;
            @(negedge clk);
            dbus_ack = 1'b0;
            n_checked++;
         end
      end

      if (n_checked == n_stores && u_dut.u_chk.fail_cnt == 0) begin
         $display(">>> PASS");
         $finish;
      end else begin
         stop_run("program ended before all stores were seen");
      end
   end

endmodule

// ==== tiny_serv.f ====
+incdir+.
tiny_serv_pkg.sv
tiny_serv_state.sv
tiny_serv_decode.sv
tiny_serv_rf.sv
tiny_serv_alu.sv
tiny_serv_ctrl.sv
tiny_serv_bufreg.sv
tiny_serv_top.sv
tb_clk_gen.sv
tiny_serv_chk.sv
tb_tiny_serv.sv

// ==== tiny_serv_alu.sv ====
`include "tiny_serv_config.svh"

module tiny_serv_alu (
   input  logic                   clk,
   input  logic                   i_cnt_en,
   input  logic [`TS_CNT_W-1:0]   i_cnt,
   input  tiny_serv_pkg::alu_op_t i_alu_op,
   input  logic                   i_rs1,
   input  logic                   i_rs2,
   input  logic                   i_imm,
   input  logic                   i_use_imm,
   output logic                   o_rd
);
   import tiny_serv_pkg::*;

   logic op_b;
   logic sub;
   logic b_add;
   logic carry_in;
   logic carry_q;
   logic sum;

   assign op_b  = i_use_imm ? i_imm : i_rs2;
   assign sub   = (i_alu_op == ALU_SUB);
   assign b_add = op_b ^ sub;

   // Carry preset at bit 0, the +1 of two's complement for SUB
   assign carry_in = (i_cnt == '0) ? sub : carry_q;
   assign sum      = i_rs1 ^ b_add ^ carry_in;

   always_ff @(posedge clk) begin
      if (i_cnt_en) begin
         carry_q <= (i_rs1 & b_add) | (carry_in & (i_rs1 ^ b_add));
      end
   end

   always_comb begin
      case (i_alu_op)
         ALU_XOR:    o_rd = i_rs1 ^ op_b;
         ALU_OR:     o_rd = i_rs1 | op_b;
         ALU_AND:    o_rd = i_rs1 & op_b;
         ALU_PASS_B: o_rd = op_b;
         default:    o_rd = sum;
      endcase
   end

endmodule

// ==== tiny_serv_bufreg.sv ====
`include "tiny_serv_config.svh"

module tiny_serv_bufreg (
   input  logic                clk,
   input  logic                i_cnt_en,
   input  logic                i_is_store,
   input  logic                i_alu_rd,
   input  logic                i_rs2,
   output logic [`TS_XLEN-1:0] o_dbus_adr,
   output logic [`TS_XLEN-1:0] o_dbus_dat
);
   logic [`TS_XLEN-1:0] adr_q;
   logic [`TS_XLEN-1:0] dat_q;

   // Shift LSB first, held once execute ends
   always_ff @(posedge clk) begin
      if (i_cnt_en & i_is_store) begin
         adr_q <= {i_alu_rd, adr_q[`TS_XLEN-1:1]};
         dat_q <= {i_rs2, dat_q[`TS_XLEN-1:1]};
      end
   end

   // Word access only
   assign o_dbus_adr = {adr_q[`TS_XLEN-1:2], 2'b00};
   assign o_dbus_dat = dat_q;

endmodule

// ==== tiny_serv_chk.sv ====
`include "tiny_serv_config.svh"

module tiny_serv_chk (
   input logic                clk,
   input logic                i_rst_n,
   input logic [`TS_XLEN-1:0] i_ibus_adr,
   input logic                i_ibus_cyc,
   input logic                i_ibus_ack,
   input logic [`TS_XLEN-1:0] i_dbus_adr,
   input logic [`TS_XLEN-1:0] i_dbus_dat,
   input logic                i_dbus_cyc,
   input logic                i_dbus_ack,
   input logic                i_is_jal,
   input logic                i_cnt_done
);
   timeunit 1ns;
   timeprecision 1ps;

   int                  fail_cnt = 0;
   logic [`TS_XLEN-1:0] prev_adr;
   logic                have_prev;
   logic                jal_seen;

   // Last acknowledged fetch, and whether a JAL retired since
   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         have_prev <= 1'b0;
         jal_seen  <= 1'b0;
      end else if (i_ibus_cyc && i_ibus_ack) begin
         prev_adr  <= i_ibus_adr;
         have_prev <= 1'b1;
         jal_seen  <= 1'b0;
      end else if (i_cnt_done && i_is_jal) begin
         jal_seen <= 1'b1;
      end
   end

   reset_idle: assert property (@(posedge clk)
      !i_rst_n |=> !i_ibus_cyc && !i_dbus_cyc)
      else begin
         fail_cnt++;
         $error("bus cycle active during reset");
      end

   ibus_hold: assert property (@(posedge clk) disable iff (!i_rst_n)
      i_ibus_cyc && !i_ibus_ack |=> i_ibus_cyc && $stable(i_ibus_adr))
      else begin
         fail_cnt++;
         $error("fetch dropped or address moved before ack");
      end

   ibus_release: assert property (@(posedge clk) disable iff (!i_rst_n)
      i_ibus_cyc && i_ibus_ack |=> !i_ibus_cyc)
      else begin
         fail_cnt++;
         $error("fetch cyc still high after ack");
      end

   dbus_hold: assert property (@(posedge clk) disable iff (!i_rst_n)
      i_dbus_cyc && !i_dbus_ack |=>
         i_dbus_cyc && $stable(i_dbus_adr) && $stable(i_dbus_dat))
      else begin
         fail_cnt++;
         $error("store dropped or address/data moved before ack");
      end

   dbus_release: assert property (@(posedge clk) disable iff (!i_rst_n)
      i_dbus_cyc && i_dbus_ack |=> !i_dbus_cyc)
      else begin
         fail_cnt++;
         $error("store cyc still high after ack");
      end

   one_bus: assert property (@(posedge clk) disable iff (!i_rst_n)
      !(i_ibus_cyc && i_dbus_cyc))
      else begin
         fail_cnt++;
         $error("ibus and dbus cycles overlap");
      end

   fetch_aligned: assert property (@(posedge clk) disable iff (!i_rst_n)
      i_ibus_cyc |-> i_ibus_adr[1:0] == 2'b00)
      else begin
         fail_cnt++;
         $error("fetch address not word aligned");
      end

   fetch_seq: assert property (@(posedge clk) disable iff (!i_rst_n)
      $rose(i_ibus_cyc) && have_prev && !jal_seen |-> i_ibus_adr == prev_adr + 32'd4)
      else begin
         fail_cnt++;
         $error("fetch address skipped without a JAL");
      end

endmodule

bind tiny_serv_top tiny_serv_chk u_chk (
   .clk        (clk),
   .i_rst_n    (i_rst_n),
   .i_ibus_adr (o_ibus_adr),
   .i_ibus_cyc (o_ibus_cyc),
   .i_ibus_ack (i_ibus_ack),
   .i_dbus_adr (o_dbus_adr),
   .i_dbus_dat (o_dbus_dat),
   .i_dbus_cyc (o_dbus_cyc),
   .i_dbus_ack (i_dbus_ack),
   .i_is_jal   (is_jal),
   .i_cnt_done (cnt_done)
);

// ==== tiny_serv_config.svh ====
`ifndef TINY_SERV_CONFIG_SVH
`define TINY_SERV_CONFIG_SVH

// Address of the first instruction fetch after reset
`define TS_RESET_PC 32'h0000_0000

// Data and address width
`define TS_XLEN 32

// Serial bit counter width
`define TS_CNT_W 5

`endif

// ==== tiny_serv_ctrl.sv ====
`include "tiny_serv_config.svh"

module tiny_serv_ctrl (
   input  logic                 clk,
   input  logic                 i_rst_n,
   input  logic                 i_cnt_en,
   input  logic [`TS_CNT_W-1:0] i_cnt,
   input  logic                 i_cnt_done,
   input  logic                 i_is_jal,
   input  logic                 i_imm,
   output logic                 o_pc_plus4,
   output logic [`TS_XLEN-1:0]  o_ibus_adr
);
   logic [`TS_XLEN-1:0] pc;
   logic [`TS_XLEN-1:0] npc_shift;
   logic                pc_bit;
   logic                four_bit;
   logic                c4_in;
   logic                c4_q;
   logic                cj_in;
   logic                cj_q;
   logic                jal_sum;
   logic                npc_bit;

   assign pc_bit   = pc[i_cnt];
   // Constant 4 has only bit 2 set
   assign four_bit = (i_cnt == `TS_CNT_W'(2));

   assign c4_in      = (i_cnt != '0) & c4_q;
   assign o_pc_plus4 = pc_bit ^ four_bit ^ c4_in;

   assign cj_in   = (i_cnt != '0) & cj_q;
   assign jal_sum = pc_bit ^ i_imm ^ cj_in;

   assign npc_bit = i_is_jal ? jal_sum : o_pc_plus4;

   always_ff @(posedge clk) begin
      if (i_cnt_en) begin
         c4_q      <= (pc_bit & four_bit) | (c4_in & (pc_bit ^ four_bit));
         cj_q      <= (pc_bit & i_imm) | (cj_in & (pc_bit ^ i_imm));
         npc_shift <= {npc_bit, npc_shift[`TS_XLEN-1:1]};
      end
   end

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         pc <= `TS_RESET_PC;
      end else if (i_cnt_done) begin
         pc <= {npc_bit, npc_shift[`TS_XLEN-1:1]};
      end
   end

   assign o_ibus_adr = pc;

endmodule

// ==== tiny_serv_decode.sv ====
`include "tiny_serv_config.svh"

module tiny_serv_decode (
   input  logic                   clk,
   input  logic                   i_ibus_ack,
   input  logic [`TS_XLEN-1:0]    i_ibus_rdt,
   input  logic                   i_cnt_en,
   input  logic [`TS_CNT_W-1:0]   i_cnt,
   output logic [4:0]             o_rs1_addr,
   output logic [4:0]             o_rs2_addr,
   output logic [4:0]             o_rd_addr,
   output tiny_serv_pkg::alu_op_t o_alu_op,
   output tiny_serv_pkg::rd_src_t o_rd_src,
   output logic                   o_use_imm,
   output logic                   o_is_store,
   output logic                   o_is_jal,
   output logic                   o_imm
);
   import tiny_serv_pkg::*;

   logic [`TS_XLEN-1:0] ir;
   opcode_t             opcode;
   logic [2:0]          funct3;
   logic                f7_ok;
   logic                f3_ok;
   alu_op_t             f3_op;

   logic [`TS_XLEN-1:0] imm_i;
   logic [`TS_XLEN-1:0] imm_s;
   logic [`TS_XLEN-1:0] imm_u;
   logic [`TS_XLEN-1:0] imm_j;
   logic [`TS_XLEN-1:0] imm_word;

   always_ff @(posedge clk) begin
      if (i_ibus_ack) begin
         ir <= i_ibus_rdt;
      end
   end

   assign opcode     = opcode_t'(ir[6:0]);
   assign funct3     = ir[14:12];
   assign o_rd_addr  = ir[11:7];
   assign o_rs1_addr = ir[19:15];
   assign o_rs2_addr = ir[24:20];

   // Only ADD/SUB may carry funct7 bit 30
   assign f7_ok = (ir[31:25] == 7'b0000000) |
                  ((ir[31:25] == 7'b0100000) & (funct3 == 3'b000));

   assign imm_i = {{21{ir[31]}}, ir[30:20]};
   assign imm_s = {{21{ir[31]}}, ir[30:25], ir[11:7]};
   assign imm_u = {ir[31:12], 12'b0};
   assign imm_j = {{12{ir[31]}}, ir[19:12], ir[20], ir[30:21], 1'b0};

   always_comb begin
      f3_ok = 1'b1;
      case (funct3)
         3'b000:  f3_op = ALU_ADD;
         3'b100:  f3_op = ALU_XOR;
         3'b110:  f3_op = ALU_OR;
         3'b111:  f3_op = ALU_AND;
         default: begin
            f3_op = ALU_ADD;
            f3_ok = 1'b0;
         end
      endcase
   end

   always_comb begin
      o_alu_op   = ALU_ADD;
      o_rd_src   = RD_NONE;
      o_use_imm  = 1'b0;
      o_is_store = 1'b0;
      o_is_jal   = 1'b0;
      imm_word   = imm_i;
      case (opcode)
         OPC_OP_IMM: begin
            o_alu_op  = f3_op;
            o_use_imm = 1'b1;
            o_rd_src  = f3_ok ? RD_ALU : RD_NONE;
         end
         OPC_OP: begin
            o_alu_op = ir[30] ? ALU_SUB : f3_op;
            o_rd_src = (f3_ok & f7_ok) ? RD_ALU : RD_NONE;
         end
         OPC_LUI: begin
            o_alu_op  = ALU_PASS_B;
            o_use_imm = 1'b1;
            o_rd_src  = RD_ALU;
            imm_word  = imm_u;
         end
         OPC_JAL: begin
            o_is_jal = 1'b1;
            o_rd_src = RD_PC4;
            imm_word = imm_j;
         end
         OPC_STORE: begin
            // Word stores only, rs1 + offset goes to the address buffer
            o_use_imm  = 1'b1;
            o_is_store = (funct3 == 3'b010);
            imm_word   = imm_s;
         end
         default: begin
            o_rd_src = RD_NONE;
         end
      endcase
   end

   // Immediate streamed LSB first
   assign o_imm = i_cnt_en & imm_word[i_cnt];

endmodule

// ==== tiny_serv_pkg.sv ====
package tiny_serv_pkg;

   // RV32 major opcodes handled by the core
   typedef enum logic [6:0] {
      OPC_OP_IMM = 7'b0010011,
      OPC_OP     = 7'b0110011,
      OPC_LUI    = 7'b0110111,
      OPC_JAL    = 7'b1101111,
      OPC_STORE  = 7'b0100011
   } opcode_t;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_XOR,
      ALU_OR,
      ALU_AND,
      ALU_PASS_B
   } alu_op_t;

   // Source of the serial rd write stream
   typedef enum logic [1:0] {
      RD_NONE,
      RD_ALU,
      RD_PC4
   } rd_src_t;

   typedef enum logic [1:0] {
      ST_FETCH,
      ST_EXEC,
      ST_STORE
   } seq_state_t;

endpackage

// ==== tiny_serv_rf.sv ====
`include "tiny_serv_config.svh"

module tiny_serv_rf (
   input  logic                   clk,
   input  logic                   i_rst_n,
   input  logic                   i_cnt_en,
   input  logic [`TS_CNT_W-1:0]   i_cnt,
   input  logic                   i_cnt_done,
   input  logic [4:0]             i_rs1_addr,
   input  logic [4:0]             i_rs2_addr,
   input  logic [4:0]             i_rd_addr,
   input  tiny_serv_pkg::rd_src_t i_rd_src,
   input  logic                   i_alu_rd,
   input  logic                   i_pc_plus4,
   output logic                   o_rs1,
   output logic                   o_rs2
);
   import tiny_serv_pkg::*;

   logic [`TS_XLEN-1:0] regs [0:31];
   logic [`TS_XLEN-1:0] rd_shift;
   logic [31:0]         written;
   logic                rd_bit;
   logic                rd_wen;

   always_comb begin
      case (i_rd_src)
         RD_ALU:  rd_bit = i_alu_rd;
         RD_PC4:  rd_bit = i_pc_plus4;
         default: rd_bit = 1'b0;
      endcase
   end

   // x0 never written
   assign rd_wen = i_cnt_done & (i_rd_src != RD_NONE) & (i_rd_addr != 5'd0);

   always_ff @(posedge clk) begin
      if (i_cnt_en) begin
         rd_shift <= {rd_bit, rd_shift[`TS_XLEN-1:1]};
      end
      if (rd_wen) begin
         regs[i_rd_addr] <= {rd_bit, rd_shift[`TS_XLEN-1:1]};
      end
   end

   // Registers read as zero until first written
   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         written <= '0;
      end else if (rd_wen) begin
         written[i_rd_addr] <= 1'b1;
      end
   end

   assign o_rs1 = written[i_rs1_addr] & regs[i_rs1_addr][i_cnt];
   assign o_rs2 = written[i_rs2_addr] & regs[i_rs2_addr][i_cnt];

endmodule

// ==== tiny_serv_state.sv ====
`include "tiny_serv_config.svh"

module tiny_serv_state (
   input  logic                 clk,
   input  logic                 i_rst_n,
   input  logic                 i_ibus_ack,
   input  logic                 i_dbus_ack,
   input  logic                 i_is_store,
   output logic                 o_ibus_cyc,
   output logic                 o_dbus_cyc,
   output logic                 o_cnt_en,
   output logic [`TS_CNT_W-1:0] o_cnt,
   output logic                 o_cnt_done
);
   import tiny_serv_pkg::*;

   seq_state_t state;

   assign o_cnt_en   = (state == ST_EXEC);
   // Last of the 32 serial cycles
   assign o_cnt_done = o_cnt_en & (&o_cnt);

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         state      <= ST_FETCH;
         o_ibus_cyc <= 1'b0;
         o_dbus_cyc <= 1'b0;
         o_cnt      <= '0;
      end else begin
         case (state)
            ST_FETCH: begin
               // Only taken on the way out of reset
               if (!o_ibus_cyc) begin
                  o_ibus_cyc <= 1'b1;
               end else if (i_ibus_ack) begin
                  o_ibus_cyc <= 1'b0;
                  state      <= ST_EXEC;
               end
            end
            ST_EXEC: begin
               o_cnt <= o_cnt + `TS_CNT_W'(1);
               if (o_cnt_done) begin
                  if (i_is_store) begin
                     o_dbus_cyc <= 1'b1;
                     state      <= ST_STORE;
                  end else begin
                     o_ibus_cyc <= 1'b1;
                     state      <= ST_FETCH;
                  end
               end
            end
            ST_STORE: begin
               if (i_dbus_ack) begin
                  o_dbus_cyc <= 1'b0;
                  o_ibus_cyc <= 1'b1;
                  state      <= ST_FETCH;
               end
            end
            default: begin
               o_ibus_cyc <= 1'b0;
               o_dbus_cyc <= 1'b0;
               state      <= ST_FETCH;
            end
         endcase
      end
   end

endmodule

// ==== tiny_serv_top.sv ====
`include "tiny_serv_config.svh"

module tiny_serv_top (
   input  logic                clk,
   input  logic                i_rst_n,
   output logic [`TS_XLEN-1:0] o_ibus_adr,
   output logic                o_ibus_cyc,
   input  logic [`TS_XLEN-1:0] i_ibus_rdt,
   input  logic                i_ibus_ack,
   output logic [`TS_XLEN-1:0] o_dbus_adr,
   output logic [`TS_XLEN-1:0] o_dbus_dat,
   output logic                o_dbus_cyc,
   input  logic                i_dbus_ack
);
   import tiny_serv_pkg::*;

   logic                 cnt_en;
   logic [`TS_CNT_W-1:0] cnt;
   logic                 cnt_done;

   logic [4:0] rs1_addr;
   logic [4:0] rs2_addr;
   logic [4:0] rd_addr;
   alu_op_t    alu_op;
   rd_src_t    rd_src;
   logic       use_imm;
   logic       is_store;
   logic       is_jal;
   logic       imm;

   // Serial data streams
   logic rs1;
   logic rs2;
   logic alu_rd;
   logic pc_plus4;

   tiny_serv_state u_state (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_ibus_ack (i_ibus_ack),
      .i_dbus_ack (i_dbus_ack),
      .i_is_store (is_store),
      .o_ibus_cyc (o_ibus_cyc),
      .o_dbus_cyc (o_dbus_cyc),
      .o_cnt_en   (cnt_en),
      .o_cnt      (cnt),
      .o_cnt_done (cnt_done)
   );

   tiny_serv_decode u_decode (
      .clk        (clk),
      .i_ibus_ack (i_ibus_ack),
      .i_ibus_rdt (i_ibus_rdt),
      .i_cnt_en   (cnt_en),
      .i_cnt      (cnt),
      .o_rs1_addr (rs1_addr),
      .o_rs2_addr (rs2_addr),
      .o_rd_addr  (rd_addr),
      .o_alu_op   (alu_op),
      .o_rd_src   (rd_src),
      .o_use_imm  (use_imm),
      .o_is_store (is_store),
      .o_is_jal   (is_jal),
      .o_imm      (imm)
   );

   tiny_serv_rf u_rf (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_cnt_en   (cnt_en),
      .i_cnt      (cnt),
      .i_cnt_done (cnt_done),
      .i_rs1_addr (rs1_addr),
      .i_rs2_addr (rs2_addr),
      .i_rd_addr  (rd_addr),
      .i_rd_src   (rd_src),
      .i_alu_rd   (alu_rd),
      .i_pc_plus4 (pc_plus4),
      .o_rs1      (rs1),
      .o_rs2      (rs2)
   );

   tiny_serv_alu u_alu (
      .clk       (clk),
      .i_cnt_en  (cnt_en),
      .i_cnt     (cnt),
      .i_alu_op  (alu_op),
      .i_rs1     (rs1),
      .i_rs2     (rs2),
      .i_imm     (imm),
      .i_use_imm (use_imm),
      .o_rd      (alu_rd)
   );

   tiny_serv_ctrl u_ctrl (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_cnt_en   (cnt_en),
      .i_cnt      (cnt),
      .i_cnt_done (cnt_done),
      .i_is_jal   (is_jal),
      .i_imm      (imm),
      .o_pc_plus4 (pc_plus4),
      .o_ibus_adr (o_ibus_adr)
   );

   tiny_serv_bufreg u_bufreg (
      .clk        (clk),
      .i_cnt_en   (cnt_en),
      .i_is_store (is_store),
      .i_alu_rd   (alu_rd),
      .i_rs2      (rs2),
      .o_dbus_adr (o_dbus_adr),
      .o_dbus_dat (o_dbus_dat)
   );

endmodule
